// ==== list.f ====
hw/lmfe_pkg.sv
hw/line_buffer.sv
hw/running_median.sv
hw/window_sequencer.sv
hw/lmfe_top.sv
bench/lmfe_checker.sv
bench/lmfe_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the median filter testbench with Verilator, verdict from the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module lmfe_tb -f list.f -o lmfe_sim \
	&& ./obj_dir/lmfe_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "Simulation completed successfully" sim.log && echo "run: PASS" && exit 0 \
	|| { echo "run: FAIL"; exit 1; }

// ==== bench/lmfe_tb.sv ====
`timescale 1ns/10ps

module lmfe_tb;

	localparam int WIN = 7;
	localparam int IMG_W = 16;
	localparam int IMG_H = 16;
	localparam int AREA = IMG_W * IMG_H;
	localparam int FRAMES = 7; // frames sent over all tests
	localparam int LIMIT = FRAMES * AREA * (2 * WIN * WIN + 4) + 4 * AREA + 100;

	logic clk;
	logic rst;
	logic in_en;
	lmfe_pkg::pixel_t din;
	logic busy;
	logic out_valid;
	lmfe_pkg::pixel_t dout;
	lmfe_pkg::pixel_t frame [AREA];
	int cycles;

	lmfe_top #(
		.WIN(WIN),
		.IMG_W(IMG_W),
		.IMG_H(IMG_H)
	) DUT (
		.clk(clk),
		.rst(rst),
		.in_en(in_en),
		.din(din),
		.busy(busy),
		.out_valid(out_valid),
		.dout(dout)
	);

	lmfe_checker #(
		.WIN(WIN),
		.IMG_W(IMG_W),
		.IMG_H(IMG_H)
	) u_chk (
		.clk(clk),
		.rst(rst),
		.in_en(in_en),
		.busy(busy),
		.out_valid(out_valid),
		.dout(dout)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic fill_frame(input bit rand_px, input lmfe_pkg::pixel_t v);
		for (int i = 0; i < AREA; i++) begin
			frame[i] = rand_px ? lmfe_pkg::pixel_t'($urandom) : v;
		end
	endtask

	// entered and left 1 ns after a rising edge
	task automatic send_frame(input bit gaps);
		for (int i = 0; i < AREA; i++) begin
			u_chk.push_pixel(frame[i]);
		end
		for (int i = 0; i < AREA; i++) begin
			while (busy || (gaps && $urandom % 4 == 0)) begin
				in_en = 1'b0;
				@(posedge clk);
				#1;
			end
			in_en = 1'b1;
			din = frame[i];
			@(posedge clk);
			#1;
		end
		in_en = 1'b0;
		while (busy) begin // remaining output rows of the frame
			@(posedge clk);
			#1;
		end
	endtask

	initial begin
		void'($urandom(32'h58fb49c0));
		rst = 1'b1;
		in_en = 1'b0;
		din = '0;
		repeat (10) @(posedge clk);
		#1;
		rst = 1'b0;
		fill_frame(1'b0, 8'd97);
		send_frame(1'b0);
		u_chk.end_test("constant", 1);
		fill_frame(1'b0, 8'd255);
		send_frame(1'b0);
		u_chk.end_test("all_255", 1);
		fill_frame(1'b1, '0);
		send_frame(1'b0);
		u_chk.end_test("random", 1);
		fill_frame(1'b1, '0);
		send_frame(1'b0);
		u_chk.check_count("back_to_back", 1); // first frame alone
		fill_frame(1'b1, '0);
		send_frame(1'b0);
		u_chk.end_test("back_to_back", 2);
		fill_frame(1'b1, '0);
		send_frame(1'b0);
		u_chk.end_test("steady_stream", 1);
		send_frame(1'b1); // same frame again, with random gaps
		u_chk.end_test("gapped_stream", 1);
		u_chk.report_totals();
		if (u_chk.errors == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

	initial begin
		cycles = 0;
		while (cycles < LIMIT) begin
			@(posedge clk);
			cycles = cycles + 1;
		end
		$display("timeout: the tests did not finish within %0d cycles", LIMIT);
		$display("Simulation failed");
		$finish;
	end

endmodule

// ==== bench/lmfe_checker.sv ====
`timescale 1ns/10ps

module lmfe_checker #(
	parameter int WIN = 7,
	parameter int IMG_W = 16,
	parameter int IMG_H = 16
) (
	input logic clk,
	input logic rst,
	input logic in_en,
	input logic busy,
	input logic out_valid,
	input lmfe_pkg::pixel_t dout
);

	localparam int R = (WIN - 1) / 2;
	localparam int AREA = IMG_W * IMG_H;

	lmfe_pkg::pixel_t pix [$]; // every frame sent since reset, back to back
	int out_n = 0;
	int in_n = 0; // pixels accepted in the current frame
	int test_first = 0;
	int test_err0 = 0;
	int errors = 0;
	int failed = 0;
	logic busy_hi_due = 1'b0;
	logic busy_lo_due = 1'b0;

	// median of the window around (r, c), samples outside the image count as 0
	function automatic lmfe_pkg::pixel_t ref_median(input int base, input int r, input int c);
		lmfe_pkg::pixel_t w [WIN*WIN];
		lmfe_pkg::pixel_t t;
		int n;
		int rr;
		int cc;
		n = 0;
		for (int dr = -R; dr <= R; dr++) begin
			for (int dc = -R; dc <= R; dc++) begin
				rr = r + dr;
				cc = c + dc;
				if (rr < 0 || rr >= IMG_H || cc < 0 || cc >= IMG_W) begin
					w[n] = '0;
				end else begin
					w[n] = pix[base + rr * IMG_W + cc];
				end
				n++;
			end
		end
		for (int i = 1; i < WIN * WIN; i++) begin // insertion sort, ascending
			for (int k = i; k > 0 && w[k-1] > w[k]; k--) begin
				t = w[k];
				w[k] = w[k-1];
				w[k-1] = t;
			end
		end
		return w[(WIN * WIN - 1) / 2];
	endfunction

	task automatic push_pixel(input lmfe_pkg::pixel_t p);
		pix.push_back(p);
	endtask

	task automatic check_count(input string name, input int frames);
		int got;
		got = out_n - test_first;
		if (got != frames * AREA) begin
			$display("test %s gave %0d output pixels instead of %0d", name, got, frames * AREA);
			errors++;
		end
	endtask

	task automatic end_test(input string name, input int frames);
		int got;
		got = out_n - test_first;
		check_count(name, frames);
		if (errors != test_err0) begin
			failed++;
		end
		$display("test %s: %0d pixels, %0d errors", name, got, errors - test_err0);
		test_first = out_n;
		test_err0 = errors;
	endtask

	task automatic report_totals();
		$display("tests failed %0d, output pixels %0d, errors %0d", failed, out_n, errors);
	endtask

	// dout and out_valid settle between edges
	always @(negedge clk) begin
		int f;
		int p;
		lmfe_pkg::pixel_t want;
		if (rst) begin
			if (busy !== 1'b0 || out_valid !== 1'b0) begin
				$display("error at %0t: busy or out_valid high during reset", $time);
				errors++;
			end
		end else begin
			if (busy_hi_due && busy !== 1'b1) begin
				$display("error at %0t: busy low after a row that starts an output row", $time);
				errors++;
			end
			if (busy_lo_due && busy !== 1'b0) begin
				$display("error at %0t: busy still high after the output row ended", $time);
				errors++;
			end
			busy_hi_due = 1'b0;
			busy_lo_due = 1'b0;
			if (in_en && !busy) begin
				// last pixel of input row R or later starts an output row
				busy_hi_due = (in_n % IMG_W == IMG_W - 1) && (in_n / IMG_W >= R);
				in_n = (in_n + 1) % AREA;
			end
			if (out_valid) begin
				f = out_n / AREA; // results follow the frames in raster order
				p = out_n % AREA;
				if (pix.size() < (f + 1) * AREA) begin
					$display("output pixel %0d came with no frame sent for it", out_n);
					errors++;
				end else begin
					want = ref_median(f * AREA, p / IMG_W, p % IMG_W);
					if (dout !== want) begin
						$display("error at %0t: frame %0d row %0d col %0d got %0d expected %0d",
							$time, f, p / IMG_W, p % IMG_W, dout, want);
						errors++;
					end
				end
				// busy drops after an output row unless the next one needs no input
				busy_lo_due = (p % IMG_W == IMG_W - 1)
					&& (p / IMG_W == IMG_H - 1 || p / IMG_W < IMG_H - 1 - R);
				out_n++;
			end
		end
	end

endmodule

// ==== hw/lmfe_top.sv ====
`timescale 1ns/10ps

module lmfe_top #(
	parameter int WIN = 7,
	parameter int IMG_W = 16,
	parameter int IMG_H = 16
) (
	input logic clk,
	input logic rst,
	input logic in_en,
	input lmfe_pkg::pixel_t din,
	output logic busy,
	output logic out_valid,
	output lmfe_pkg::pixel_t dout
);

	lmfe_pkg::lb_wr_t wr;
	lmfe_pkg::pixel_t wr_data;
	lmfe_pkg::pixel_t rd_data;
	logic [lmfe_pkg::WIN_BITS-1:0] rd_slot;
	logic [lmfe_pkg::MAX_W_BITS-1:0] rd_col;
	lmfe_pkg::sort_cmd_t cmd;

	window_sequencer #(
		.WIN(WIN),
		.IMG_W(IMG_W),
		.IMG_H(IMG_H)
	) u_seq (
		.clk(clk),
		.rst(rst),
		.in_en(in_en),
		.din(din),
		.busy(busy),
		.out_valid(out_valid),
		.wr(wr),
		.wr_data(wr_data),
		.rd_slot(rd_slot),
		.rd_col(rd_col),
		.rd_data(rd_data),
		.cmd(cmd)
	);

	line_buffer #(
		.WIN(WIN),
		.IMG_W(IMG_W)
	) u_lbuf (
		.clk(clk),
		.wr(wr),
		.wr_data(wr_data),
		.rd_slot(rd_slot),
		.rd_col(rd_col),
		.rd_data(rd_data)
	);

	running_median #(
		.WIN(WIN)
	) u_med (
		.clk(clk),
		.rst(rst),
		.cmd(cmd),
		.median(dout) // middle of the sorted window
	);

endmodule

// ==== hw/window_sequencer.sv ====
`timescale 1ns/10ps

module window_sequencer #(
	parameter int WIN = 7,
	parameter int IMG_W = 16,
	parameter int IMG_H = 16
) (
	input logic clk,
	input logic rst,
	input logic in_en,
	input lmfe_pkg::pixel_t din,
	output logic busy,
	output logic out_valid,
	output lmfe_pkg::lb_wr_t wr,
	output lmfe_pkg::pixel_t wr_data,
	output logic [lmfe_pkg::WIN_BITS-1:0] rd_slot,
	output logic [lmfe_pkg::MAX_W_BITS-1:0] rd_col,
	input lmfe_pkg::pixel_t rd_data,
	output lmfe_pkg::sort_cmd_t cmd
);

	localparam int R = (WIN - 1) / 2;
	localparam int SLOT_W = lmfe_pkg::WIN_BITS;
	localparam int COL_W = lmfe_pkg::MAX_W_BITS;
	localparam logic [COL_W-1:0] LAST_COL = COL_W'(IMG_W - 1);
	localparam logic [COL_W-1:0] LAST_ROW = COL_W'(IMG_H - 1);
	localparam logic [COL_W-1:0] FIRST_OUT = COL_W'(R); // input row that completes output row 0
	localparam logic [SLOT_W-1:0] K_LAST = SLOT_W'(WIN - 1);

	typedef enum logic [1:0] {ST_ACCEPT, ST_FILL, ST_SLIDE, ST_DONE} state_t;
	typedef enum logic [1:0] {OP_NONE, OP_CLR, OP_INS, OP_DEL} op_t;

	state_t state;
	logic [COL_W-1:0] in_row;
	logic [COL_W-1:0] in_col;
	logic in_last; // whole frame is in the line buffer
	logic [COL_W-1:0] out_row;
	logic [COL_W-1:0] out_col;
	logic [SLOT_W-1:0] k; // window row
	logic [SLOT_W-1:0] j; // window column, fill only
	logic phase;
	logic accept;
	op_t op;
	op_t op_q;
	logic pad;
	logic pad_q;
	logic px_last;
	logic last_q;
	int smp_row;
	int smp_col;

	assign busy = (state != ST_ACCEPT);
	assign accept = in_en && !busy;

	always_comb begin
		wr.en = accept;
		wr.row_slot = SLOT_W'(in_row % WIN);
		wr.col = in_col;
	end

	assign wr_data = din;

	// issue stage: pick the op and the sample it needs
	always_comb begin
		op = OP_NONE;
		smp_col = 0;
		px_last = 1'b0;
		case (state)
			ST_FILL: begin
				op = phase ? OP_INS : OP_CLR;
				smp_col = int'(j) - R;
				px_last = phase && (k == K_LAST) && (j == K_LAST);
			end
			ST_SLIDE: begin
				op = phase ? OP_INS : OP_DEL;
				smp_col = phase ? int'(out_col) + R : int'(out_col) - R - 1;
				px_last = phase && (k == K_LAST);
			end
			default: begin
			end
		endcase
		smp_row = int'(out_row) + int'(k) - R;
		pad = (op != OP_INS && op != OP_DEL) || smp_row < 0 || smp_row >= IMG_H
			|| smp_col < 0 || smp_col >= IMG_W;
	end

	assign rd_slot = pad ? '0 : SLOT_W'(smp_row % WIN);
	assign rd_col = pad ? '0 : COL_W'(smp_col);

	always_ff @(posedge clk) begin
		pad_q <= pad;
	end

	// command stage, one cycle behind the read
	always_comb begin
		cmd.clear = (op_q == OP_CLR);
		cmd.insert = (op_q == OP_INS);
		cmd.delete = (op_q == OP_DEL);
		cmd.value = pad_q ? '0 : rd_data;
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= ST_ACCEPT;
			in_row <= '0;
			in_col <= '0;
			in_last <= 1'b0;
			out_row <= '0;
			out_col <= '0;
			k <= '0;
			j <= '0;
			phase <= 1'b0;
			op_q <= OP_NONE;
			last_q <= 1'b0;
			out_valid <= 1'b0;
		end else begin
			op_q <= op;
			last_q <= px_last;
			out_valid <= last_q;
			case (state)
				ST_ACCEPT: begin
					if (accept && in_col == LAST_COL) begin
						in_col <= '0;
						in_row <= (in_row == LAST_ROW) ? '0 : in_row + 1'b1;
						if (in_row == LAST_ROW) begin
							in_last <= 1'b1;
						end
						if (in_row >= FIRST_OUT || in_row == LAST_ROW) begin
							state <= ST_FILL;
						end
					end else if (accept) begin
						in_col <= in_col + 1'b1;
					end
				end
				ST_FILL, ST_SLIDE: begin
					if (px_last) begin
						phase <= 1'b0;
						k <= '0;
						j <= '0;
						if (out_col == LAST_COL) begin
							state <= ST_DONE;
						end else begin
							out_col <= out_col + 1'b1;
							state <= ST_SLIDE;
						end
					end else if (state == ST_FILL && !phase) begin
						phase <= 1'b1; // clear issued
					end else if (k == K_LAST) begin
						k <= '0;
						if (state == ST_FILL) begin
							j <= j + 1'b1;
						end else begin
							phase <= 1'b1;
						end
					end else begin
						k <= k + 1'b1;
					end
				end
				ST_DONE: begin
					// hold until the row's last result is out
					if (out_valid) begin
						out_col <= '0;
						if (out_row == LAST_ROW) begin
							out_row <= '0;
							in_last <= 1'b0;
							state <= ST_ACCEPT;
						end else begin
							out_row <= out_row + 1'b1;
							state <= in_last ? ST_FILL : ST_ACCEPT;
						end
					end
				end
				default: begin
					state <= ST_ACCEPT;
				end
			endcase
		end
	end

	a_one_cmd: assert property (@(posedge clk) disable iff (rst)
		$onehot0({cmd.clear, cmd.insert, cmd.delete}));

	a_valid_busy: assert property (@(posedge clk) disable iff (rst)
		out_valid |-> busy);

endmodule

// ==== hw/running_median.sv ====
`timescale 1ns/10ps

module running_median #(
	parameter int WIN = 7
) (
	input logic clk,
	input logic rst,
	input lmfe_pkg::sort_cmd_t cmd,
	output lmfe_pkg::pixel_t median
);

	localparam int N = WIN * WIN;
	localparam int MID = (N - 1) / 2;
	localparam int CNT_W = $clog2(N + 1);
	localparam logic [CNT_W-1:0] FULL = CNT_W'(N);

	lmfe_pkg::pixel_t list [N];
	lmfe_pkg::pixel_t list_nxt [N];
	logic [CNT_W-1:0] count;
	logic [N-1:0] above; // slot at or past the insert point
	logic [N-1:0] above_prev;
	logic [N-1:0] at_or_above; // slot at or past the entry to delete

	always_comb begin
		for (int i = 0; i < N; i++) begin
			above[i] = (CNT_W'(i) >= count) || (list[i] > cmd.value);
			at_or_above[i] = (CNT_W'(i) >= count) || (list[i] >= cmd.value);
		end
	end

	assign above_prev = above << 1;

	always_comb begin
		for (int i = 0; i < N; i++) begin
			if (cmd.clear) begin
				list_nxt[i] = lmfe_pkg::PIXEL_MAX;
			end else if (cmd.insert && above[i]) begin
				// first slot above the value takes it, the rest move up
				list_nxt[i] = above_prev[i] ? list[(i == 0) ? 0 : i - 1] : cmd.value;
			end else if (cmd.delete && at_or_above[i]) begin
				list_nxt[i] = (i == N - 1) ? lmfe_pkg::PIXEL_MAX : list[(i == N - 1) ? i : i + 1];
			end else begin
				list_nxt[i] = list[i];
			end
		end
	end

	always_ff @(posedge clk) begin
		list <= list_nxt;
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			count <= '0;
		end else if (cmd.clear) begin
			count <= '0;
		end else if (cmd.insert) begin
			count <= count + 1'b1;
		end else if (cmd.delete) begin
			count <= count - 1'b1;
		end
	end

	assign median = list[MID];

	a_no_overflow: assert property (@(posedge clk) disable iff (rst)
		cmd.insert |-> count < FULL);

	a_no_underflow: assert property (@(posedge clk) disable iff (rst)
		cmd.delete |-> count != '0);

endmodule

// ==== hw/line_buffer.sv ====
`timescale 1ns/10ps

module line_buffer #(
	parameter int WIN = 7,
	parameter int IMG_W = 16
) (
	input logic clk,
	input lmfe_pkg::lb_wr_t wr,
	input lmfe_pkg::pixel_t wr_data,
	input logic [lmfe_pkg::WIN_BITS-1:0] rd_slot,
	input logic [lmfe_pkg::MAX_W_BITS-1:0] rd_col,
	output lmfe_pkg::pixel_t rd_data
);

	localparam int DEPTH = WIN * IMG_W;
	localparam int AW = $clog2(DEPTH);

	lmfe_pkg::pixel_t mem [DEPTH];
	logic [AW-1:0] wr_addr;
	logic [AW-1:0] rd_addr;

	// rows sit back to back, one IMG_W stretch per slot
	assign wr_addr = AW'(wr.row_slot * IMG_W + wr.col);
	assign rd_addr = AW'(rd_slot * IMG_W + rd_col);

	always_ff @(posedge clk) begin
		if (wr.en) begin
			mem[wr_addr] <= wr_data;
		end
		rd_data <= mem[rd_addr]; // registered read
	end

	a_wr_range: assert property (@(posedge clk)
		wr.en |-> (wr.col < IMG_W) && (wr.row_slot < WIN));

	// the sequencer parks the read address in range while idle
	a_rd_range: assert property (@(posedge clk)
		(rd_col < IMG_W) && (rd_slot < WIN));

endmodule

// ==== hw/lmfe_pkg.sv ====
package lmfe_pkg;

	typedef logic [7:0] pixel_t;

	localparam pixel_t PIXEL_MAX = 8'hff; // fills empty sorter slots

	// sized for the largest supported image width and window
	localparam int MAX_W_BITS = 10;
	localparam int WIN_BITS = 4;

	typedef struct packed {
		logic clear;
		logic insert;
		logic delete;
		pixel_t value;
	} sort_cmd_t;

	typedef struct packed {
		logic en;
		logic [WIN_BITS-1:0] row_slot; // image row modulo WIN
		logic [MAX_W_BITS-1:0] col;
	} lb_wr_t;

endpackage
